// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - files:
      - design/csr_pkg.sv
      - design/csr_regfile.sv
      - design/csr_op_unit.sv
      - design/trap_ctrl.sv
      - design/csr_unit_top.sv
  - target: test
    files:
      - tb/csr_unit_tb.sv

// ==== compile.f ====
design/csr_pkg.sv
design/csr_regfile.sv
design/csr_op_unit.sv
design/trap_ctrl.sv
design/csr_unit_top.sv
tb/csr_unit_tb.sv

// ==== design/csr_op_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_op_unit (
    input  logic                           instr_valid,
    input  csr_pkg::csr_op_e               instr_op,
    input  logic                           instr_kill,
    input  logic [csr_pkg::csr_addr_w-1:0] csr_addr,
    input  logic [csr_pkg::xlen-1:0]       src_data,
    input  logic                           src_is_zero,
    input  logic [csr_pkg::xlen-1:0]       rd_data,
    input  logic                           addr_hit,
    output logic                           csr_wen,
    output logic [csr_pkg::csr_addr_w-1:0] csr_waddr,
    output logic [csr_pkg::xlen-1:0]       csr_wdata,
    output logic                           illegal
);
    import csr_pkg::*;

    logic is_csr_op;
    logic is_set_clr;
    logic op_active;
    logic no_write;

    assign is_csr_op  = (instr_op == op_csrrw) ||
                        (instr_op == op_csrrs) ||
                        (instr_op == op_csrrc);
    assign is_set_clr = (instr_op == op_csrrs) || (instr_op == op_csrrc);

    // Preempted instructions do nothing
    assign op_active = instr_valid && !instr_kill && is_csr_op;

    // Set/clear with x0 or zero immediate is a pure read
    assign no_write = is_set_clr && src_is_zero;

    //////////////////////////////////////////////////////////////////////
    // New value
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (instr_op)
            op_csrrw: csr_wdata = src_data;
            op_csrrs: csr_wdata = rd_data | src_data;
            op_csrrc: csr_wdata = rd_data & ~src_data;
            default:  csr_wdata = rd_data;
        endcase
    end

    assign csr_waddr = csr_addr;
    assign csr_wen   = op_active && addr_hit && !no_write;
    assign illegal   = op_active && !addr_hit;

    // Writes only reach known CSRs
    always_comb begin
        a_wen_hit : assert final (!csr_wen || addr_hit)
            else $error("csr_op_unit: write to unknown CSR");
    end

endmodule

`default_nettype wire

// ==== design/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    ////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////
    localparam int xlen       = 64;
    localparam int csr_addr_w = 12;

    ////////////////////////////////////////////////////////////////////
    // Machine CSR addresses
    ////////////////////////////////////////////////////////////////////
    localparam logic [csr_addr_w-1:0] addr_mstatus  = 12'h300;
    localparam logic [csr_addr_w-1:0] addr_mtvec    = 12'h305;
    localparam logic [csr_addr_w-1:0] addr_mscratch = 12'h340;
    localparam logic [csr_addr_w-1:0] addr_mepc     = 12'h341;
    localparam logic [csr_addr_w-1:0] addr_mcause   = 12'h342;

    // MPP = 3, SXL/UXL = 2
    localparam logic [xlen-1:0] mstatus_reset = 64'ha00001800;

    localparam int mie_bit  = 3;
    localparam int mpie_bit = 7;

    // Interrupt flag in the top bit
    localparam logic [xlen-1:0] cause_ecall_m   = 64'd11;
    localparam logic [xlen-1:0] cause_ext_irq_m = {1'b1, 63'd11};

    typedef enum logic [2:0] {
        op_none,
        op_csrrw,
        op_csrrs,
        op_csrrc,
        op_ecall,
        op_mret
    } csr_op_e;

endpackage

`default_nettype wire

// ==== design/csr_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_regfile (
    input  logic                           I_sys_clk,
    input  logic                           I_rst,
    input  logic                           csr_wen,
    input  logic [csr_pkg::csr_addr_w-1:0] csr_waddr,
    input  logic [csr_pkg::xlen-1:0]       csr_wdata,
    input  logic                           trap_wr,
    input  logic [csr_pkg::xlen-1:0]       trap_cause,
    input  logic [csr_pkg::xlen-1:0]       trap_pc,
    input  logic                           mret_wr,
    input  logic [csr_pkg::csr_addr_w-1:0] raddr,
    output logic [csr_pkg::xlen-1:0]       rd_data,
    output logic                           addr_hit,
    output logic                           mstatus_mie,
    output logic [csr_pkg::xlen-1:0]       mtvec,
    output logic [csr_pkg::xlen-1:0]       mepc
);
    import csr_pkg::*;

    logic [xlen-1:0] mstatus;
    logic [xlen-1:0] mcause;
    logic [xlen-1:0] mscratch;

    assign mstatus_mie = mstatus[mie_bit];

    //////////////////////////////////////////////////////////////////////
    // Register update
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            mstatus  <= mstatus_reset;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mscratch <= '0;
        end else if (csr_wen) begin
            case (csr_waddr)
                addr_mstatus:  mstatus  <= csr_wdata;
                addr_mtvec:    mtvec    <= csr_wdata;
                addr_mepc:     mepc     <= csr_wdata;
                addr_mcause:   mcause   <= csr_wdata;
                addr_mscratch: mscratch <= csr_wdata;
                default: ;
            endcase
        end else if (trap_wr) begin
            mepc              <= trap_pc;
            mcause            <= trap_cause;
            mstatus[mpie_bit] <= mstatus[mie_bit]; // Save interrupt enable
            mstatus[mie_bit]  <= 1'b0;
        end else if (mret_wr) begin
            mstatus[mie_bit]  <= mstatus[mpie_bit];
            mstatus[mpie_bit] <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        addr_hit = 1'b1;
        case (raddr)
            addr_mstatus:  rd_data = mstatus;
            addr_mtvec:    rd_data = mtvec;
            addr_mepc:     rd_data = mepc;
            addr_mcause:   rd_data = mcause;
            addr_mscratch: rd_data = mscratch;
            default: begin
                rd_data  = '0; // Unknown CSR reads zero
                addr_hit = 1'b0;
            end
        endcase
    end

    // Enables come from two different blocks
    a_one_writer : assert property (
        @(posedge I_sys_clk) disable iff (I_rst)
        $onehot0({csr_wen, trap_wr, mret_wr})
    ) else $error("csr_regfile: more than one write enable high");

endmodule

`default_nettype wire

// ==== design/csr_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_top (
    input  logic                           I_sys_clk,
    input  logic                           I_rst,
    input  logic                           I_instr_valid,
    input  csr_pkg::csr_op_e               I_instr_op,
    input  logic [csr_pkg::xlen-1:0]       I_instr_pc,
    input  logic [csr_pkg::csr_addr_w-1:0] I_csr_addr,
    input  logic [csr_pkg::xlen-1:0]       I_src_data,
    input  logic                           I_src_is_zero,
    input  logic                           I_ext_irq,
    output logic [csr_pkg::xlen-1:0]       O_rd_data,
    output logic                           O_illegal,
    output logic                           O_redirect,
    output logic [csr_pkg::xlen-1:0]       O_redirect_pc
);
    import csr_pkg::*;

    logic                  csr_wen;
    logic [csr_addr_w-1:0] csr_waddr;
    logic [xlen-1:0]       csr_wdata;
    logic                  addr_hit;
    logic                  trap_wr;
    logic [xlen-1:0]       trap_cause;
    logic [xlen-1:0]       trap_pc;
    logic                  mret_wr;
    logic                  mstatus_mie;
    logic [xlen-1:0]       mtvec;
    logic [xlen-1:0]       mepc;
    logic                  instr_kill;

    csr_regfile u_regfile (
        .I_sys_clk   (I_sys_clk),
        .I_rst       (I_rst),
        .csr_wen     (csr_wen),
        .csr_waddr   (csr_waddr),
        .csr_wdata   (csr_wdata),
        .trap_wr     (trap_wr),
        .trap_cause  (trap_cause),
        .trap_pc     (trap_pc),
        .mret_wr     (mret_wr),
        .raddr       (I_csr_addr),
        .rd_data     (O_rd_data), // Value before the write
        .addr_hit    (addr_hit),
        .mstatus_mie (mstatus_mie),
        .mtvec       (mtvec),
        .mepc        (mepc)
    );

    csr_op_unit u_op (
        .instr_valid (I_instr_valid),
        .instr_op    (I_instr_op),
        .instr_kill  (instr_kill),
        .csr_addr    (I_csr_addr),
        .src_data    (I_src_data),
        .src_is_zero (I_src_is_zero),
        .rd_data     (O_rd_data),
        .addr_hit    (addr_hit),
        .csr_wen     (csr_wen),
        .csr_waddr   (csr_waddr),
        .csr_wdata   (csr_wdata),
        .illegal     (O_illegal)
    );

    trap_ctrl u_trap (
        .I_sys_clk   (I_sys_clk),
        .I_rst       (I_rst),
        .instr_valid (I_instr_valid),
        .instr_op    (I_instr_op),
        .instr_pc    (I_instr_pc),
        .ext_irq     (I_ext_irq),
        .mstatus_mie (mstatus_mie),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .instr_kill  (instr_kill),
        .trap_wr     (trap_wr),
        .trap_cause  (trap_cause),
        .trap_pc     (trap_pc),
        .mret_wr     (mret_wr),
        .redirect    (O_redirect),
        .redirect_pc (O_redirect_pc)
    );

endmodule

`default_nettype wire

// ==== design/trap_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl (
    input  logic                     I_sys_clk,
    input  logic                     I_rst,
    input  logic                     instr_valid,
    input  csr_pkg::csr_op_e         instr_op,
    input  logic [csr_pkg::xlen-1:0] instr_pc,
    input  logic                     ext_irq,
    input  logic                     mstatus_mie,
    input  logic [csr_pkg::xlen-1:0] mtvec,
    input  logic [csr_pkg::xlen-1:0] mepc,
    output logic                     instr_kill,
    output logic                     trap_wr,
    output logic [csr_pkg::xlen-1:0] trap_cause,
    output logic [csr_pkg::xlen-1:0] trap_pc,
    output logic                     mret_wr,
    output logic                     redirect,
    output logic [csr_pkg::xlen-1:0] redirect_pc
);
    import csr_pkg::*;

    logic irq_d;
    logic irq_rise;
    logic irq_pending;
    logic irq_take;
    logic ecall_take;
    logic mret_take;

    //////////////////////////////////////////////////////////////////////
    // Interrupt pending
    //////////////////////////////////////////////////////////////////////
    assign irq_rise = ext_irq && !irq_d;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            irq_d       <= 1'b0;
            irq_pending <= 1'b0;
        end else begin
            irq_d       <= ext_irq;
            irq_pending <= irq_rise || (irq_pending && !irq_take); // New edge wins
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Arbitration: interrupt, then ecall/mret
    //////////////////////////////////////////////////////////////////////
    assign irq_take   = instr_valid && irq_pending && mstatus_mie;
    assign ecall_take = instr_valid && !irq_take && (instr_op == op_ecall);
    assign mret_take  = instr_valid && !irq_take && (instr_op == op_mret);

    assign instr_kill = irq_take;
    assign trap_wr    = irq_take || ecall_take;
    assign trap_cause = irq_take ? cause_ext_irq_m : cause_ecall_m;
    assign trap_pc    = instr_pc; // Preempted or faulting pc
    assign mret_wr    = mret_take;

    assign redirect    = trap_wr || mret_wr;
    assign redirect_pc = mret_take ? mepc : mtvec; // Direct mode only

    a_redirect_valid : assert property (
        @(posedge I_sys_clk) disable iff (I_rst)
        redirect |-> instr_valid
    ) else $error("trap_ctrl: redirect without valid instruction");

endmodule

`default_nettype wire

// ==== tb/csr_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;
    import csr_pkg::*;

    localparam int irq_wait_max = 20;
    localparam logic [csr_addr_w-1:0] csr_addrs [5] = '{
        addr_mstatus, addr_mtvec, addr_mepc, addr_mcause, addr_mscratch
    };

    logic                  I_sys_clk;
    logic                  I_rst;
    logic                  I_instr_valid;
    csr_op_e               I_instr_op;
    logic [xlen-1:0]       I_instr_pc;
    logic [csr_addr_w-1:0] I_csr_addr;
    logic [xlen-1:0]       I_src_data;
    logic                  I_src_is_zero;
    logic                  I_ext_irq;
    logic [xlen-1:0]       O_rd_data;
    logic                  O_illegal;
    logic                  O_redirect;
    logic [xlen-1:0]       O_redirect_pc;

    logic [xlen-1:0] m_csr [5]; // Same order as csr_addrs
    logic            m_irq_d;
    logic            m_pending;
    int              exp_idx;
    logic            exp_hit;
    logic            exp_is_csr;
    logic            exp_take;
    logic [xlen-1:0] exp_rd;
    logic            exp_illegal;
    logic            exp_redirect;
    logic [xlen-1:0] exp_redirect_pc;
    integer          seed;
    int              err_count;
    int              timeout_count;
    string           test_name;
    logic [xlen-1:0] next_pc;
    logic            seen;
    int              n;

    csr_unit_top u_dut (.*);

    always #20 I_sys_clk = ~I_sys_clk;

    function automatic int csr_index(input logic [csr_addr_w-1:0] a);
        for (int i = 0; i < 5; i++) begin
            if (csr_addrs[i] == a) return i;
        end
        return -1;
    endfunction

    function automatic logic [xlen-1:0] new_value(input csr_op_e op,
                                                  input logic [xlen-1:0] old,
                                                  input logic [xlen-1:0] src);
        if (op == op_csrrs) return old | src;
        if (op == op_csrrc) return old & ~src;
        return src;
    endfunction

    function automatic logic [xlen-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        exp_idx     = csr_index(I_csr_addr);
        exp_hit     = (exp_idx >= 0);
        exp_rd      = exp_hit ? m_csr[exp_idx] : '0;
        exp_is_csr  = I_instr_valid && (I_instr_op inside {op_csrrw, op_csrrs, op_csrrc});
        exp_take    = I_instr_valid && m_pending && m_csr[0][mie_bit];
        exp_illegal = exp_is_csr && !exp_take && !exp_hit;
        exp_redirect = exp_take ||
                       (I_instr_valid && (I_instr_op inside {op_ecall, op_mret}));
        exp_redirect_pc = (!exp_take && I_instr_op == op_mret) ? m_csr[2] : m_csr[1];
    end

    always @(posedge I_sys_clk) begin
        if (I_rst) begin
            m_csr     <= '{mstatus_reset, '0, '0, '0, '0};
            m_irq_d   <= 1'b0;
            m_pending <= 1'b0;
        end else begin
            m_irq_d   <= I_ext_irq;
            m_pending <= (I_ext_irq && !m_irq_d) || (m_pending && !exp_take);
            if (exp_take || (I_instr_valid && I_instr_op == op_ecall)) begin
                m_csr[2]           <= I_instr_pc;
                m_csr[3]           <= exp_take ? cause_ext_irq_m : cause_ecall_m;
                m_csr[0][mpie_bit] <= m_csr[0][mie_bit];
                m_csr[0][mie_bit]  <= 1'b0;
            end else if (I_instr_valid && I_instr_op == op_mret) begin
                m_csr[0][mie_bit]  <= m_csr[0][mpie_bit];
                m_csr[0][mpie_bit] <= 1'b1;
            end else if (exp_is_csr && exp_hit &&
                         !(I_src_is_zero && I_instr_op != op_csrrw)) begin
                m_csr[exp_idx] <= new_value(I_instr_op, exp_rd, I_src_data);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////
    a_rd_data : assert property (@(posedge I_sys_clk) disable iff (I_rst)
        I_instr_valid |-> O_rd_data == exp_rd
    ) else begin
        err_count++;
        $display("FAILED %s rd_data expected %h actual %h", test_name,
                 $sampled(exp_rd), $sampled(O_rd_data));
    end

    a_illegal : assert property (@(posedge I_sys_clk) disable iff (I_rst)
        O_illegal == exp_illegal
    ) else begin
        err_count++;
        $display("FAILED %s illegal expected %b actual %b", test_name,
                 $sampled(exp_illegal), $sampled(O_illegal));
    end

    a_redirect : assert property (@(posedge I_sys_clk) disable iff (I_rst)
        O_redirect == exp_redirect
    ) else begin
        err_count++;
        $display("FAILED %s redirect expected %b actual %b", test_name,
                 $sampled(exp_redirect), $sampled(O_redirect));
    end

    a_redirect_pc : assert property (@(posedge I_sys_clk) disable iff (I_rst)
        exp_redirect |-> O_redirect_pc == exp_redirect_pc
    ) else begin
        err_count++;
        $display("FAILED %s redirect_pc expected %h actual %h", test_name,
                 $sampled(exp_redirect_pc), $sampled(O_redirect_pc));
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////
    task automatic issue(input csr_op_e op, input logic [csr_addr_w-1:0] addr,
                         input logic [xlen-1:0] data, input logic zero);
        @(posedge I_sys_clk);
        I_instr_valid <= 1'b1;
        I_instr_op    <= op;
        I_instr_pc    <= next_pc;
        I_csr_addr    <= addr;
        I_src_data    <= data;
        I_src_is_zero <= zero;
        next_pc       += 4;
    endtask

    task automatic read_all();
        for (int i = 0; i < 5; i++) begin
            issue(op_csrrs, csr_addrs[i], '0, 1'b1); // Pure read
        end
    endtask

    initial begin
        seed          = 32'hf643;
        err_count     = 0;
        timeout_count = 0;
        next_pc       = 64'h8000_0000;
        test_name     = "reset";
        I_sys_clk     = 1'b0;
        I_rst         <= 1'b1;
        I_instr_valid <= 1'b0;
        I_instr_op    <= op_none;
        I_instr_pc    <= '0;
        I_csr_addr    <= '0;
        I_src_data    <= '0;
        I_src_is_zero <= 1'b0;
        I_ext_irq     <= 1'b0;
        repeat (3) @(posedge I_sys_clk);
        I_rst <= 1'b0;
        read_all();

        test_name = "csrrw";
        for (n = 0; n < 5; n++) issue(op_csrrw, csr_addrs[n], rand64(), 1'b0);
        read_all();

        test_name = "csrrs_csrrc";
        for (n = 0; n < 5; n++) begin
            issue(op_csrrs, csr_addrs[n], rand64(), 1'b0);
            issue(op_csrrc, csr_addrs[n], rand64(), 1'b0);
            issue(op_csrrs, csr_addrs[n], rand64(), 1'b1); // Zero source, no write
            issue(op_csrrc, csr_addrs[n], rand64(), 1'b1);
        end
        issue(op_csrrw, 12'h7c0, rand64(), 1'b0); // Unknown CSR
        issue(op_csrrs, 12'h7c1, rand64(), 1'b0);
        read_all();

        test_name = "ecall";
        issue(op_csrrw, addr_mtvec, rand64(), 1'b0);
        issue(op_csrrs, addr_mstatus, 64'h8, 1'b0);
        issue(op_ecall, '0, '0, 1'b0);
        read_all();
        issue(op_ecall, '0, '0, 1'b0); // MIE clear, so MPIE clears
        read_all();

        test_name = "mret";
        issue(op_mret, '0, '0, 1'b0); // MIE restored from a clear MPIE
        read_all();
        issue(op_mret, '0, '0, 1'b0);
        read_all();

        test_name = "irq_masked";
        issue(op_csrrc, addr_mstatus, 64'h8, 1'b0);
        I_ext_irq <= 1'b1;
        seen = 1'b0;
        for (n = 0; n < 8 && !seen; n++) begin
            issue(op_none, '0, '0, 1'b0);
            @(negedge I_sys_clk);
            seen = O_redirect;
        end

        test_name = "irq_taken";
        issue(op_csrrs, addr_mstatus, 64'h8, 1'b0);
        seen = 1'b0;
        for (n = 0; n < irq_wait_max && !seen; n++) begin
            issue(op_csrrw, addr_mscratch, rand64(), 1'b0); // First one gets preempted
            @(negedge I_sys_clk);
            seen = O_redirect;
        end
        if (!seen) begin
            timeout_count++;
            $display("Timeout: no interrupt redirect after MIE was set");
        end
        read_all();
        I_ext_irq <= 1'b0;

        @(posedge I_sys_clk);
        I_instr_valid <= 1'b0;
        repeat (2) @(posedge I_sys_clk);
        $display("Errors: %0d check, %0d timeout", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
